/* project.f */
+incdir+tests
verilog/led_matrix_pkg.sv
verilog/control_latch_encoder.sv
verilog/pixel_store.sv
verilog/frame_sequencer.sv
verilog/grayscale_serializer.sv
verilog/led_matrix_top.sv
tests/tb_led_matrix.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_led_matrix -f project.f

out=$(./obj_dir/Vtb_led_matrix)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

/* tests/tb_led_matrix_model.svh */
`ifndef TB_LED_MATRIX_MODEL_SVH
`define TB_LED_MATRIX_MODEL_SVH

// copy of every pixel write by line, driver and channel
logic [led_matrix_pkg::GS_BITS-1:0] shadow
	[NUM_LINES][NUM_DRIVERS][led_matrix_pkg::GS_CHANNELS];

// builds the whole 769-bit control word from the field map and then picks one bit
function automatic logic expected_control_bit(input led_matrix_pkg::led_ctrl_cfg_t cfg,
	input int index);
	logic [led_matrix_pkg::LATCH_BITS-1:0] word;
	int base;
	word = '0;  // unused bits stay 0
	for (int g = 0; g < led_matrix_pkg::GS_CHANNELS / 3; g++) begin
		base = led_matrix_pkg::DC_BASE + 21 * g;  // one r/g/b group
		word[base +: 7]      = cfg.dc_r;
		word[base + 7 +: 7]  = cfg.dc_g;
		word[base + 14 +: 7] = cfg.dc_b;
	end
	word[led_matrix_pkg::MC_BASE +: 3]      = cfg.mc_r;  // max current
	word[led_matrix_pkg::MC_BASE + 3 +: 3]  = cfg.mc_g;
	word[led_matrix_pkg::MC_BASE + 6 +: 3]  = cfg.mc_b;
	word[led_matrix_pkg::BC_BASE +: 7]      = cfg.bc_r;  // global brightness
	word[led_matrix_pkg::BC_BASE + 7 +: 7]  = cfg.bc_g;
	word[led_matrix_pkg::BC_BASE + 14 +: 7] = cfg.bc_b;
	// function bits in datasheet order
	word[led_matrix_pkg::FC_BASE]     = cfg.dsprpt;
	word[led_matrix_pkg::FC_BASE + 1] = cfg.tmgrst;
	word[led_matrix_pkg::FC_BASE + 2] = cfg.rfresh;
	word[led_matrix_pkg::FC_BASE + 3] = cfg.espwm;
	word[led_matrix_pkg::FC_BASE + 4] = cfg.lsdvlt;
	word[led_matrix_pkg::LATCH_BITS - 1] = 1'b1;  // select = control
	return word[index];
endfunction

// grayscale word with channel 47 on top and each value msb first
function automatic logic expected_gs_bit(input int ln, input int drv, input int index);
	int chan;
	int bit_pos;
	if (index == led_matrix_pkg::LATCH_BITS - 1)
		return 1'b0;  // select = grayscale
	chan    = index / led_matrix_pkg::GS_BITS;
	bit_pos = index % led_matrix_pkg::GS_BITS;
	return shadow[ln][drv][chan][bit_pos];
endfunction

`endif

/* tests/tb_led_matrix.sv */
module tb_led_matrix;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LINES   = 4;
	localparam int NUM_DRIVERS = 2;
	localparam int LBITS       = led_matrix_pkg::LATCH_BITS;
	localparam int CHANS       = led_matrix_pkg::GS_CHANNELS;
	localparam int PASS_BITS   = LBITS * NUM_DRIVERS;                 // sclk rises per pass
	localparam int PASS_CYCLES = NUM_DRIVERS * (2 * LBITS + 1) + 1;   // start to busy low
	localparam int WRITES      = NUM_LINES * NUM_DRIVERS * CHANS;
	localparam int WATCHDOG_CYCLES = 5 * PASS_CYCLES + 10 + 2 * WRITES + 200;

	logic CLK;
	logic reset;
	led_matrix_pkg::pixel_write_t  pix_wr;
	led_matrix_pkg::led_ctrl_cfg_t ctrl_cfg;
	logic frame_start;
	logic [NUM_LINES-1:0] sdo;
	logic sclk;
	logic lat;
	logic busy;

	integer seed;
	string test_name;                         // shown in error lines
	led_matrix_pkg::latch_kind_e exp_kind;    // what the next pass should carry
	logic [NUM_LINES-1:0] cap [PASS_BITS];    // sdo per rising sclk in pass order
	int cap_cnt      = 0;
	int lat_cnt      = 0;
	int bit_errs     = 0;
	int sclk_errs    = 0;
	int mon_errs     = 0;
	int stim_errs    = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	`include "tb_led_matrix_model.svh"

	led_matrix_top #(
		.NUM_LINES   (NUM_LINES),
		.NUM_DRIVERS (NUM_DRIVERS)
	) u_led_matrix_top (
		.CLK         (CLK),
		.reset       (reset),
		.pix_wr      (pix_wr),
		.ctrl_cfg    (ctrl_cfg),
		.frame_start (frame_start),
		.sdo         (sdo),
		.sclk        (sclk),
		.lat         (lat),
		.busy        (busy)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;  // 100 MHz
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	// sdo is stable through the sclk high cycle so it is captured there
	always @(posedge CLK) begin
		if (reset || lat) begin
			cap_cnt <= 0;  // next pass starts clean
		end else if (sclk) begin
			if (cap_cnt < PASS_BITS)
				cap[cap_cnt] <= sdo;
			cap_cnt <= cap_cnt + 1;
		end
	end

	// compare at the latch edge while the capture still holds the finished pass
	always @(posedge CLK) begin
		int drv;
		int idx;
		int fails;
		logic exp_bit;
		if (!reset && lat) begin
			fails = 0;
			if (cap_cnt != PASS_BITS) begin
				$display("[ERROR] %s sclk edges before lat: expected %0d, actual %0d",
				         test_name, PASS_BITS, cap_cnt);
				sclk_errs++;
			end
			for (int k = 0; k < PASS_BITS; k++) begin
				drv = NUM_DRIVERS - 1 - k / LBITS;  // farthest driver first
				idx = LBITS - 1 - k % LBITS;        // select bit first
				for (int l = 0; l < NUM_LINES; l++) begin
					if (exp_kind == led_matrix_pkg::LATCH_CONTROL)
						exp_bit = expected_control_bit(ctrl_cfg, idx);
					else
						exp_bit = expected_gs_bit(l, drv, idx);
					if (cap[k][l] !== exp_bit) begin
						if (fails < 8)
							$display("[ERROR] %s line %0d driver %0d bit %0d: expected %0b, actual %0b",
							         test_name, l, drv, idx, exp_bit, cap[k][l]);
						fails++;
					end
				end
			end
			if (fails > 8)
				$display("%s has %0d more bit mismatches not shown", test_name, fails - 8);
			bit_errs += fails;
			lat_cnt++;
		end
	end

	// drivers must never see a latch during a shift clock
	always @(posedge CLK) begin
		if (!reset && lat && sclk) begin
			$display("lat and sclk were high in the same cycle during %s", test_name);
			mon_errs++;
		end
	end

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("test %s: %s", name, ok ? "ok" : "failed");
	endtask

	task automatic write_pixel(input int l, input int d, input int c,
		input logic [led_matrix_pkg::GS_BITS-1:0] v);
		led_matrix_pkg::pixel_write_t wr;
		wr.we      = 1'b1;
		wr.line    = led_matrix_pkg::LINE_IDX_W'(l);
		wr.driver  = led_matrix_pkg::DRIVER_IDX_W'(d);
		wr.channel = led_matrix_pkg::CHAN_IDX_W'(c);
		wr.value   = v;
		@(posedge CLK);
		pix_wr <= wr;
		shadow[l][d][c] = v;  // model follows every write
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy !== 1'b0 && n < PASS_CYCLES + 50) begin
			@(posedge CLK);
			n++;
		end
		if (busy !== 1'b0) begin
			$display("busy did not fall within %0d cycles", PASS_CYCLES + 50);
			stim_errs++;
		end
	endtask

	// strobe frame_start and count busy cycles after the cycle it is taken
	task automatic run_frame(input bit extra_start, output int cycles);
		int n;
		n = 0;
		@(posedge CLK);
		frame_start <= 1'b1;
		@(posedge CLK);  // sequencer takes the strobe here
		frame_start <= 1'b0;
		while (n <= PASS_CYCLES + 50) begin
			@(posedge CLK);
			if (busy !== 1'b1)
				break;
			n++;
			frame_start <= (extra_start && n == PASS_CYCLES / 2);  // lands mid-pass
		end
		frame_start <= 1'b0;
		if (n > PASS_CYCLES + 50) begin
			$display("%s frame did not end, busy stayed high", test_name);
			stim_errs++;
		end
		cycles = n;
	endtask

	initial begin
		logic [63:0] cfg_raw;
		int cycles;
		int lat_before;
		int errs_before;
		seed        = 32'h31fa_8c30;
		reset       = 1'b1;
		frame_start = 1'b0;
		pix_wr      = '0;
		cfg_raw     = {$random(seed), $random(seed)};
		ctrl_cfg    = cfg_raw[$bits(led_matrix_pkg::led_ctrl_cfg_t)-1:0];
		exp_kind    = led_matrix_pkg::LATCH_CONTROL;  // first pass after reset
		test_name   = "control_latch";
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		wait_idle();
		if (lat_cnt != 1)
			$display("[ERROR] control_latch lat pulses: expected 1, actual %0d", lat_cnt);
		report_test("control_latch", bit_errs == 0 && lat_cnt == 1 && busy === 1'b0);

		// one random value per line, driver and channel
		test_name = "grayscale_frame";
		for (int l = 0; l < NUM_LINES; l++)
			for (int d = 0; d < NUM_DRIVERS; d++)
				for (int c = 0; c < CHANS; c++)
					write_pixel(l, d, c, led_matrix_pkg::GS_BITS'($random(seed)));
		@(posedge CLK);
		pix_wr <= '0;
		exp_kind    = led_matrix_pkg::LATCH_GRAYSCALE;
		errs_before = bit_errs;
		lat_before  = lat_cnt;
		run_frame(1'b0, cycles);
		if (lat_cnt != lat_before + 1)
			$display("[ERROR] grayscale_frame lat pulses: expected 1, actual %0d",
			         lat_cnt - lat_before);
		report_test("grayscale_frame", bit_errs == errs_before && lat_cnt == lat_before + 1);
		if (cycles != PASS_CYCLES)
			$display("[ERROR] pass_length: expected %0d, actual %0d", PASS_CYCLES, cycles);
		report_test("pass_length", cycles == PASS_CYCLES);

		// even channels get new values, odd ones must survive
		test_name = "rewrite_frame";
		for (int l = 0; l < NUM_LINES; l++)
			for (int d = 0; d < NUM_DRIVERS; d++)
				for (int c = 0; c < CHANS; c += 2)
					write_pixel(l, d, c, led_matrix_pkg::GS_BITS'($random(seed)));
		@(posedge CLK);
		pix_wr <= '0;
		errs_before = bit_errs;
		lat_before  = lat_cnt;
		run_frame(1'b1, cycles);  // second strobe while busy
		repeat (20) @(posedge CLK);
		report_test("rewrite_frame", bit_errs == errs_before && lat_cnt > lat_before);
		if (lat_cnt != lat_before + 1)
			$display("[ERROR] busy_frame_start lat pulses: expected %0d, actual %0d",
			         1, lat_cnt - lat_before);
		report_test("busy_frame_start", lat_cnt == lat_before + 1 && busy === 1'b0);
		report_test("sclk_and_lat", sclk_errs == 0 && mon_errs == 0);

		$display("tests %0d, failed %0d, bit errors %0d, other errors %0d",
		         tests_run, tests_failed, bit_errs, sclk_errs + mon_errs + stim_errs);
		if (tests_failed == 0 && bit_errs == 0 && sclk_errs + mon_errs + stim_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* verilog/control_latch_encoder.sv */
module control_latch_encoder (
	input  led_matrix_pkg::shift_pos_t    pos,
	input  led_matrix_pkg::led_ctrl_cfg_t ctrl_cfg,
	output logic                          ctrl_bit
);

	// field widths and ends
	localparam int DC_W      = 7;
	localparam int DC_STRIDE = 3 * DC_W;                      // one r/g/b group
	localparam int DC_GROUPS = led_matrix_pkg::GS_CHANNELS / 3;
	localparam int DC_END    = led_matrix_pkg::DC_BASE + DC_GROUPS * DC_STRIDE;
	localparam int MC_W      = 3;
	localparam int MC_END    = led_matrix_pkg::MC_BASE + 3 * MC_W;
	localparam int BC_W      = 7;
	localparam int BC_END    = led_matrix_pkg::BC_BASE + 3 * BC_W;
	localparam int FC_BITS   = 5;
	localparam int FC_END    = led_matrix_pkg::FC_BASE + FC_BITS;
	localparam int SELECT_BIT = led_matrix_pkg::LATCH_BITS - 1;

	logic [FC_BITS-1:0] fc_vec;

	// bit 0 of the field is dsprpt at FC_BASE
	assign fc_vec = {ctrl_cfg.lsdvlt, ctrl_cfg.espwm, ctrl_cfg.rfresh,
	                 ctrl_cfg.tmgrst, ctrl_cfg.dsprpt};

	// color 0 red, 1 green, 2 blue
	function automatic logic pick_rgb(input logic [6:0] r, input logic [6:0] g,
		input logic [6:0] b, input int unsigned color, input int unsigned bitpos);
		logic [6:0] fld;
		case (color)
			0:       fld = r;
			1:       fld = g;
			default: fld = b;
		endcase
		return fld[bitpos[2:0]];
	endfunction

	always_comb begin
		int unsigned idx;
		int unsigned off;
		idx      = pos.bit_index;
		off      = 0;
		ctrl_bit = 1'b0;  // reserved bits stay 0
		if (idx == SELECT_BIT) begin
			ctrl_bit = 1'b1;  // selects the control latch
		end else if (idx < DC_END) begin
			off      = (idx - led_matrix_pkg::DC_BASE) % DC_STRIDE;  // every group alike
			ctrl_bit = pick_rgb(ctrl_cfg.dc_r, ctrl_cfg.dc_g, ctrl_cfg.dc_b,
			                    off / DC_W, off % DC_W);
		end else if (idx >= led_matrix_pkg::MC_BASE && idx < MC_END) begin
			off      = idx - led_matrix_pkg::MC_BASE;
			ctrl_bit = pick_rgb({4'b0, ctrl_cfg.mc_r}, {4'b0, ctrl_cfg.mc_g},
			                    {4'b0, ctrl_cfg.mc_b}, off / MC_W, off % MC_W);
		end else if (idx >= led_matrix_pkg::BC_BASE && idx < BC_END) begin
			off      = idx - led_matrix_pkg::BC_BASE;
			ctrl_bit = pick_rgb(ctrl_cfg.bc_r, ctrl_cfg.bc_g, ctrl_cfg.bc_b,
			                    off / BC_W, off % BC_W);
		end else if (idx >= led_matrix_pkg::FC_BASE && idx < FC_END) begin
			off      = idx - led_matrix_pkg::FC_BASE;
			ctrl_bit = fc_vec[off[2:0]];
		end
	end

endmodule

/* verilog/frame_sequencer.sv */
module frame_sequencer #(
	parameter int NUM_DRIVERS = 2
) (
	input  logic                       CLK,
	input  logic                       reset,
	input  logic                       frame_start,  // only seen in IDLE
	output led_matrix_pkg::shift_pos_t pos,
	output logic                       load_bit,
	output logic                       sclk,
	output logic                       lat,
	output logic                       busy
);

	localparam int DW = led_matrix_pkg::DRIVER_IDX_W;
	localparam int BW = led_matrix_pkg::BIT_IDX_W;
	localparam logic [DW-1:0] LAST_DRIVER = DW'(NUM_DRIVERS - 1);  // farthest in chain
	localparam logic [BW-1:0] TOP_BIT = BW'(led_matrix_pkg::LATCH_BITS - 1);

	led_matrix_pkg::seq_state_e state;
	logic [BW-1:0] bit_cnt;
	logic [DW-1:0] drv_cnt;
	logic pending_ctrl;  // control latch still owed after reset

	always_ff @(posedge CLK) begin
		if (reset) begin
			state        <= led_matrix_pkg::SETUP;  // control pass starts by itself
			pending_ctrl <= 1'b1;
			drv_cnt      <= LAST_DRIVER;
			bit_cnt      <= TOP_BIT;
		end else begin
			case (state)
				led_matrix_pkg::IDLE: begin
					if (frame_start) begin
						state   <= led_matrix_pkg::SETUP;
						drv_cnt <= LAST_DRIVER;
					end
				end
				led_matrix_pkg::SETUP: begin
					bit_cnt <= TOP_BIT;  // select bit goes first
					state   <= led_matrix_pkg::SHIFT_LOW;
				end
				led_matrix_pkg::SHIFT_LOW: begin
					state <= led_matrix_pkg::SHIFT_HIGH;
				end
				led_matrix_pkg::SHIFT_HIGH: begin
					if (bit_cnt != '0) begin
						bit_cnt <= bit_cnt - 1'b1;
						state   <= led_matrix_pkg::SHIFT_LOW;
					end else if (drv_cnt != '0) begin
						drv_cnt <= drv_cnt - 1'b1;  // next word one driver closer
						state   <= led_matrix_pkg::SETUP;
					end else begin
						state <= led_matrix_pkg::LATCH;  // whole chain loaded
					end
				end
				led_matrix_pkg::LATCH: begin
					pending_ctrl <= 1'b0;
					state        <= led_matrix_pkg::IDLE;
				end
				default: state <= led_matrix_pkg::IDLE;
			endcase
		end
	end

	assign pos.kind = pending_ctrl ? led_matrix_pkg::LATCH_CONTROL
	                               : led_matrix_pkg::LATCH_GRAYSCALE;
	assign pos.driver    = drv_cnt;
	assign pos.bit_index = bit_cnt;

	// pins decoded straight from state
	assign load_bit = (state == led_matrix_pkg::SHIFT_LOW);
	assign sclk     = (state == led_matrix_pkg::SHIFT_HIGH);  // drivers sample on rise
	assign lat      = (state == led_matrix_pkg::LATCH);
	assign busy     = (state != led_matrix_pkg::IDLE);

	// a pass never mixes control and grayscale words
	kind_stable_in_pass: assert property (@(posedge CLK) disable iff (reset)
		busy && !lat |=> $stable(pos.kind))
		else $error("latch kind changed during a pass");

endmodule

/* verilog/grayscale_serializer.sv */
module grayscale_serializer #(
	parameter int NUM_LINES   = 4,
	parameter int NUM_DRIVERS = 2
) (
	input  logic                                    CLK,
	input  logic                                    reset,
	input  led_matrix_pkg::shift_pos_t              pos,
	input  logic                                    load_bit,
	input  logic                                    ctrl_bit,   // same on every line
	output logic [led_matrix_pkg::DRIVER_IDX_W-1:0] rd_driver,
	output logic [led_matrix_pkg::CHAN_IDX_W-1:0]   rd_channel,
	input  logic [NUM_LINES-1:0][led_matrix_pkg::GS_BITS-1:0] rd_values,
	output logic [NUM_LINES-1:0]                    sdo
);

	localparam int CW = led_matrix_pkg::CHAN_IDX_W;
	localparam int SB = $clog2(led_matrix_pkg::GS_BITS);  // bit-in-value width
	localparam int SELECT_BIT = led_matrix_pkg::LATCH_BITS - 1;

	logic is_select;
	logic [SB-1:0] gs_bit;  // bit inside the 16-bit value

	assign is_select = (pos.bit_index == SELECT_BIT);
	assign gs_bit    = pos.bit_index[SB-1:0];

	// channel = index / 16 and parked at 0 for the select bit
	assign rd_channel = is_select ? '0 : CW'(pos.bit_index >> SB);
	assign rd_driver  = pos.driver;

	always_ff @(posedge CLK) begin
		if (reset) begin
			sdo <= '0;
		end else if (load_bit) begin
			for (int l = 0; l < NUM_LINES; l++) begin
				if (pos.kind == led_matrix_pkg::LATCH_CONTROL)
					sdo[l] <= ctrl_bit;
				else if (is_select)
					sdo[l] <= 1'b0;  // grayscale select
				else
					sdo[l] <= rd_values[l][gs_bit];  // msb first as index falls
			end
		end
	end

	// sequencer must never address a driver beyond the chain
	driver_in_range: assert property (@(posedge CLK) disable iff (reset)
		load_bit |-> (pos.driver < NUM_DRIVERS))
		else $error("shift position past last driver");

endmodule

/* verilog/led_matrix_pkg.sv */
package led_matrix_pkg;

	// driver latch word
	localparam int LATCH_BITS  = 769;     // select bit sits at LATCH_BITS-1
	localparam int GS_CHANNELS = 48;      // per driver
	localparam int GS_BITS     = 16;      // per grayscale value

	// index widths
	localparam int LINE_IDX_W   = 6;      // up to 48 serial lines
	localparam int DRIVER_IDX_W = 3;      // up to 8 drivers per chain
	localparam int BIT_IDX_W    = 10;     // 0..768
	localparam int CHAN_IDX_W   = 6;      // 0..47

	// control latch field map as bit offsets inside the 769-bit word
	localparam int DC_BASE = 0;           // 16 groups of r/g/b 7-bit dot correction
	localparam int MC_BASE = 336;         // max current r/g/b with 3 bits each
	localparam int BC_BASE = 345;         // global brightness r/g/b with 7 bits each
	localparam int FC_BASE = 366;         // five function bits

	typedef enum logic {
		LATCH_CONTROL   = 1'b0,
		LATCH_GRAYSCALE = 1'b1
	} latch_kind_e;

	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		SETUP      = 3'd1,
		SHIFT_LOW  = 3'd2,                // sdo loads while sclk is low
		SHIFT_HIGH = 3'd3,                // sclk high and bit index steps down
		LATCH      = 3'd4
	} seq_state_e;

	typedef struct packed {
		logic [6:0] dc_r;                 // dot correction, same for all groups
		logic [6:0] dc_g;
		logic [6:0] dc_b;
		logic [2:0] mc_r;                 // max current
		logic [2:0] mc_g;
		logic [2:0] mc_b;
		logic [6:0] bc_r;                 // global brightness
		logic [6:0] bc_g;
		logic [6:0] bc_b;
		logic       dsprpt;               // auto display repeat
		logic       tmgrst;               // display timing reset
		logic       rfresh;               // auto data refresh
		logic       espwm;                // ES-PWM mode
		logic       lsdvlt;               // LSD detection voltage select
	} led_ctrl_cfg_t;

	typedef struct packed {
		logic                    we;
		logic [LINE_IDX_W-1:0]   line;
		logic [DRIVER_IDX_W-1:0] driver;
		logic [CHAN_IDX_W-1:0]   channel;
		logic [GS_BITS-1:0]      value;
	} pixel_write_t;

	typedef struct packed {
		latch_kind_e             kind;    // control or grayscale pass
		logic [DRIVER_IDX_W-1:0] driver;  // word being shifted
		logic [BIT_IDX_W-1:0]    bit_index; // 768 down to 0
	} shift_pos_t;

endpackage

/* verilog/led_matrix_top.sv */
module led_matrix_top #(
	parameter int NUM_LINES   = 4,
	parameter int NUM_DRIVERS = 2
) (
	input  logic                          CLK,
	input  logic                          reset,
	input  led_matrix_pkg::pixel_write_t  pix_wr,
	input  led_matrix_pkg::led_ctrl_cfg_t ctrl_cfg,  // hold stable during control pass
	input  logic                          frame_start,
	output logic [NUM_LINES-1:0]          sdo,
	output logic                          sclk,
	output logic                          lat,
	output logic                          busy
);

	led_matrix_pkg::shift_pos_t pos;        // current word and bit
	logic load_bit;                          // sdo update strobe
	logic ctrl_bit;                          // control latch bit at pos

	// pixel store read path for all lines at once
	logic [led_matrix_pkg::DRIVER_IDX_W-1:0] rd_driver;
	logic [led_matrix_pkg::CHAN_IDX_W-1:0]   rd_channel;
	logic [NUM_LINES-1:0][led_matrix_pkg::GS_BITS-1:0] rd_values;

	frame_sequencer #(
		.NUM_DRIVERS (NUM_DRIVERS)
	) u_frame_sequencer (
		.CLK         (CLK),
		.reset       (reset),
		.frame_start (frame_start),
		.pos         (pos),
		.load_bit    (load_bit),
		.sclk        (sclk),
		.lat         (lat),
		.busy        (busy)
	);

	control_latch_encoder u_control_latch_encoder (
		.pos      (pos),
		.ctrl_cfg (ctrl_cfg),
		.ctrl_bit (ctrl_bit)
	);

	grayscale_serializer #(
		.NUM_LINES   (NUM_LINES),
		.NUM_DRIVERS (NUM_DRIVERS)
	) u_grayscale_serializer (
		.CLK        (CLK),
		.reset      (reset),
		.pos        (pos),
		.load_bit   (load_bit),
		.ctrl_bit   (ctrl_bit),
		.rd_driver  (rd_driver),
		.rd_channel (rd_channel),
		.rd_values  (rd_values),
		.sdo        (sdo)
	);

	pixel_store #(
		.NUM_LINES   (NUM_LINES),
		.NUM_DRIVERS (NUM_DRIVERS)
	) u_pixel_store (
		.CLK        (CLK),
		.pix_wr     (pix_wr),
		.rd_driver  (rd_driver),
		.rd_channel (rd_channel),
		.rd_values  (rd_values)
	);

endmodule

/* verilog/pixel_store.sv */
module pixel_store #(
	parameter int NUM_LINES   = 4,
	parameter int NUM_DRIVERS = 2
) (
	input  logic                                        CLK,
	input  led_matrix_pkg::pixel_write_t                pix_wr,
	input  logic [led_matrix_pkg::DRIVER_IDX_W-1:0]     rd_driver,
	input  logic [led_matrix_pkg::CHAN_IDX_W-1:0]       rd_channel,
	output logic [NUM_LINES-1:0][led_matrix_pkg::GS_BITS-1:0] rd_values
);

	localparam int DEPTH  = NUM_DRIVERS * led_matrix_pkg::GS_CHANNELS;
	localparam int ADDR_W = $clog2(DEPTH);

	// one entry per driver/channel, holding every line's value side by side
	logic [NUM_LINES-1:0][led_matrix_pkg::GS_BITS-1:0] mem [DEPTH];

	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;

	assign wr_addr = ADDR_W'(pix_wr.driver * led_matrix_pkg::GS_CHANNELS + pix_wr.channel);
	assign rd_addr = ADDR_W'(rd_driver * led_matrix_pkg::GS_CHANNELS + rd_channel);

	always_ff @(posedge CLK) begin
		if (pix_wr.we)
			mem[wr_addr][pix_wr.line] <= pix_wr.value;  // only this line changes
	end

	assign rd_values = mem[rd_addr];  // async read as the serializer registers the bit

	// outside writer must stay inside the array
	wr_in_range: assert property (@(posedge CLK)
		pix_wr.we |-> (pix_wr.line < NUM_LINES) && (pix_wr.driver < NUM_DRIVERS) &&
		(pix_wr.channel < led_matrix_pkg::GS_CHANNELS))
		else $error("pixel write out of range");

endmodule
